// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned NUM_REGS   = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implicit
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t            r;
        i_fmt_t            i;
        s_fmt_t            s;
        b_fmt_t            b;
        u_fmt_t            u;
        j_fmt_t            j;
        logic [XLEN-1:0]   raw;
    } instr_u;

    typedef struct packed {
        alu_op_e         alu_op;
        logic            alu_src_imm;
        logic [XLEN-1:0] imm;
        logic            reg_wen;
        logic            mem_ren;
        logic            mem_wen;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            illegal;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wen;
        logic [3:0]      ben;
    } dmem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       insn;
        logic [XLEN-1:0]       pc_rdata;
        logic [XLEN-1:0]       pc_wdata;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_wdata;
        logic                  trap;
    } retire_t;

    typedef struct packed {
        logic                               valid;
        logic [63:0]                        order;
        logic [XLEN-1:0]                    insn;
        logic                               trap;
        logic [XLEN-1:0]                    pc_rdata;
        logic [XLEN-1:0]                    pc_wdata;
        logic [NUM_REGS-1:0]                x_wb;
        logic [NUM_REGS-1:0][XLEN-1:0]      x_wdata;
    } rvvi_trace_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder (
    input  rv_pkg::instr_u instr_i,
    output rv_pkg::ctrl_t  ctrl_o
);

    // shared funct3 mapping for OP and OP_IMM
    function automatic rv_pkg::alu_op_e funct3_op(input logic [2:0] funct3, input logic alt);
        rv_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = rv_pkg::ALU_ADD;
        case (instr_i.r.opcode)
            rv_pkg::OPC_LUI: begin
                ctrl_o.alu_op      = rv_pkg::ALU_PASS_B;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm         = {instr_i.u.imm, 12'b0};
                ctrl_o.reg_wen     = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.is_jal  = 1'b1;
                ctrl_o.reg_wen = 1'b1;
                ctrl_o.imm     = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12,
                                  instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
            end
            rv_pkg::OPC_BRANCH: begin
                // only beq and bne
                ctrl_o.is_branch = 1'b1;
                ctrl_o.branch_ne = funct3[0];
                ctrl_o.imm       = {{20{instr_i.b.imm12}}, instr_i.b.imm11,
                                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                ctrl_o.illegal   = (funct3[2:1] != 2'b00);
            end
            rv_pkg::OPC_LOAD: begin
                ctrl_o.mem_ren     = 1'b1;
                ctrl_o.reg_wen     = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm         = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                ctrl_o.illegal     = (funct3 != 3'b010);
            end
            rv_pkg::OPC_STORE: begin
                ctrl_o.mem_wen     = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm         = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi,
                                      instr_i.s.imm_lo};
                ctrl_o.illegal     = (funct3 != 3'b010);
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_wen     = 1'b1;
                ctrl_o.imm         = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                ctrl_o.alu_op      = funct3_op(funct3, (funct3 == 3'b101) && funct7[5]);
                // shift immediates carry a funct7 field
                if (funct3 == 3'b001) begin
                    ctrl_o.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    ctrl_o.illegal = ((funct7 & 7'b1011111) != 7'b0000000);
                end
            end
            rv_pkg::OPC_OP: begin
                ctrl_o.reg_wen = 1'b1;
                ctrl_o.alu_op  = funct3_op(funct3, funct7[5]);
                ctrl_o.illegal = (funct7 != 7'b0000000) &&
                                 !((funct7 == 7'b0100000) &&
                                   ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            default: begin
                ctrl_o.illegal = 1'b1;
            end
        endcase

        // a trap must not change any state
        if (ctrl_o.illegal) begin
            ctrl_o.reg_wen   = 1'b0;
            ctrl_o.mem_ren   = 1'b0;
            ctrl_o.mem_wen   = 1'b0;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.is_jal    = 1'b0;
        end
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  logic        wen_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [31:0] rd_wdata_i
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_wdata_i;
        end
    end

    // x0 is never written, so it reads zero
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     result_o,
    output logic            equal_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            rv_pkg::ALU_SLT:    result_o = {31'b0, lt_signed};
            rv_pkg::ALU_SLTU:   result_o = {31'b0, lt_unsigned};
            // lui goes straight through
            rv_pkg::ALU_PASS_B: result_o = b_i;
            default:            result_o = a_i + b_i;
        endcase
    end

    // branch compare on the register operands
    assign equal_o = (a_i == b_i);

endmodule

// ==== src/core.sv ====
`timescale 1ns/1ns

module core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [31:0]         imem_rdata_i,
    output logic [31:0]         imem_addr_o,
    input  logic [31:0]         dmem_rdata_i,
    output rv_pkg::dmem_req_t   dmem_req_o,
    output rv_pkg::retire_t     retire_o
);

    logic [rv_pkg::XLEN-1:0]       pc_q;
    logic                          fetch_valid_q;
    rv_pkg::instr_u                fetch_insn_q;
    logic [rv_pkg::XLEN-1:0]       fetch_pc_q;

    rv_pkg::ctrl_t                 ctrl;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       alu_b;
    logic [rv_pkg::XLEN-1:0]       alu_result;
    logic                          alu_equal;
    logic [rv_pkg::XLEN-1:0]       pc_plus4;
    logic [rv_pkg::XLEN-1:0]       target;
    logic                          branch_taken;
    logic                          redirect;
    logic                          reg_wen;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    // fetch stage
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q          <= rv_pkg::RESET_PC;
            fetch_valid_q <= 1'b0;
        end else if (redirect) begin
            // drop the instruction fetched behind the jump
            pc_q          <= target;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q          <= pc_q + 32'd4;
            fetch_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        fetch_insn_q <= imem_rdata_i;
        fetch_pc_q   <= pc_q;
    end

    // execute stage
    rv_decoder i_decoder (
        .instr_i ( fetch_insn_q ),
        .ctrl_o  ( ctrl )
    );

    assign rd_addr = fetch_insn_q.r.rd;
    assign reg_wen = fetch_valid_q && ctrl.reg_wen;

    rv_regfile i_regfile (
        .clk_i      ( clk_i ),
        .rst_n_i    ( rst_n_i ),
        .rs1_addr_i ( fetch_insn_q.r.rs1 ),
        .rs2_addr_i ( fetch_insn_q.r.rs2 ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data ),
        .wen_i      ( reg_wen ),
        .rd_addr_i  ( rd_addr ),
        .rd_wdata_i ( wb_data )
    );

    assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

    rv_alu i_alu (
        .op_i     ( ctrl.alu_op ),
        .a_i      ( rs1_data ),
        .b_i      ( alu_b ),
        .result_o ( alu_result ),
        .equal_o  ( alu_equal )
    );

    // branch and jal share the pc relative adder
    assign pc_plus4     = fetch_pc_q + 32'd4;
    assign target       = fetch_pc_q + ctrl.imm;
    assign branch_taken = ctrl.is_branch && (alu_equal ^ ctrl.branch_ne);
    assign redirect     = fetch_valid_q && (branch_taken || ctrl.is_jal);

    always_comb begin
        if (ctrl.is_jal) begin
            wb_data = pc_plus4;
        end else if (ctrl.mem_ren) begin
            wb_data = dmem_rdata_i;
        end else begin
            wb_data = alu_result;
        end
    end

    // word access only
    assign dmem_req_o.addr  = alu_result;
    assign dmem_req_o.wdata = rs2_data;
    assign dmem_req_o.wen   = fetch_valid_q && ctrl.mem_wen;
    assign dmem_req_o.ben   = 4'b1111;

    always_comb begin
        retire_o.valid    = fetch_valid_q;
        retire_o.insn     = fetch_insn_q.raw;
        retire_o.pc_rdata = fetch_pc_q;
        retire_o.pc_wdata = redirect ? target : pc_plus4;
        retire_o.rd_addr  = ctrl.reg_wen ? rd_addr : '0;
        retire_o.rd_wdata = (ctrl.reg_wen && (rd_addr != '0)) ? wb_data : '0;
        retire_o.trap     = ctrl.illegal;
    end

    a_no_store_on_trap: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(dmem_req_o.wen && retire_o.valid && retire_o.trap)
    );

endmodule

// ==== src/rvfi_tracker.sv ====
`timescale 1ns/1ns

module rvfi_tracker (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  rv_pkg::retire_t retire_i,
    output rv_pkg::retire_t retire_o,
    output logic [63:0]     order_o
);

    logic                    valid_q;
    logic [63:0]             order_q;
    rv_pkg::retire_t         retire_q;
    logic [rv_pkg::XLEN-1:0] last_pc_wdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            order_q <= '0;
        end else begin
            valid_q <= retire_i.valid;
            // index moves on once the current record has been shown
            if (valid_q) begin
                order_q <= order_q + 64'd1;
            end
        end
    end

    // payload only loads on a real retirement
    always_ff @(posedge clk_i) begin
        if (retire_i.valid) begin
            retire_q <= retire_i;
        end
        if (valid_q) begin
            last_pc_wdata_q <= retire_q.pc_wdata;
        end
    end

    always_comb begin
        retire_o       = retire_q;
        retire_o.valid = valid_q;
    end

    assign order_o = order_q;

    // control flow continuity across retirements, bubbles included
    a_pc_chain: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_q && (order_q != 64'd0)) |-> (retire_q.pc_rdata == last_pc_wdata_q)
    );

endmodule

// ==== src/rvvi_wrapper.sv ====
`timescale 1ns/1ns

module rvvi_wrapper (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [31:0]         imem_rdata_i,
    output logic [31:0]         imem_addr_o,
    input  logic [31:0]         dmem_rdata_i,
    output rv_pkg::dmem_req_t   dmem_req_o,
    output rv_pkg::rvvi_trace_t rvvi_o
);

    rv_pkg::retire_t core_retire;
    rv_pkg::retire_t trk_retire;
    logic [63:0]     trk_order;

    logic [rv_pkg::NUM_REGS-1:0]                   x_wb;
    logic [rv_pkg::NUM_REGS-1:0][rv_pkg::XLEN-1:0] x_wdata;

    core i_core (
        .clk_i        ( clk_i ),
        .rst_n_i      ( rst_n_i ),
        .imem_rdata_i ( imem_rdata_i ),
        .imem_addr_o  ( imem_addr_o ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .dmem_req_o   ( dmem_req_o ),
        .retire_o     ( core_retire )
    );

    rvfi_tracker i_tracker (
        .clk_i    ( clk_i ),
        .rst_n_i  ( rst_n_i ),
        .retire_i ( core_retire ),
        .retire_o ( trk_retire ),
        .order_o  ( trk_order )
    );

    // spread rd over the one-hot writeback view
    always_comb begin
        x_wb    = '0;
        x_wdata = '0;
        if (trk_retire.valid && (trk_retire.rd_addr != '0)) begin
            x_wb[trk_retire.rd_addr]    = 1'b1;
            x_wdata[trk_retire.rd_addr] = trk_retire.rd_wdata;
        end
    end

    always_comb begin
        rvvi_o.valid    = trk_retire.valid;
        rvvi_o.order    = trk_order;
        rvvi_o.insn     = trk_retire.insn;
        rvvi_o.trap     = trk_retire.trap;
        rvvi_o.pc_rdata = trk_retire.pc_rdata;
        rvvi_o.pc_wdata = trk_retire.pc_wdata;
        rvvi_o.x_wb     = x_wb;
        rvvi_o.x_wdata  = x_wdata;
    end

    // a trapping record writes no register either
    a_x_wb_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(rvvi_o.x_wb) && !rvvi_o.x_wb[0] &&
        !(rvvi_o.trap && (rvvi_o.x_wb != '0))
    );

endmodule

// ==== bench/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// how a row touches data memory
typedef enum logic [1:0] {
    MEM_NONE,
    MEM_STORE,
    MEM_PRELOAD
} mem_kind_e;

// columns: insn, retires, pc, pc_wdata, rd, wdata, trap, mem, addr
// store rows keep the store data in wdata, preload rows read wdata from the memory model
typedef struct packed {
    logic [31:0] insn;
    logic        retires;
    logic [31:0] pc;
    logic [31:0] pc_wdata;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        trap;
    mem_kind_e   mem;
    logic [31:0] addr;
} prog_row_t;

prog_row_t prog_table [28] = '{
    // immediate and register alu forms, lui
    '{32'h00500093, 1'b1, 32'h00, 32'h04, 5'd1,  32'h00000005, 1'b0, MEM_NONE, 32'h0},
    '{32'hFFD00113, 1'b1, 32'h04, 32'h08, 5'd2,  32'hFFFFFFFD, 1'b0, MEM_NONE, 32'h0},
    '{32'h002081B3, 1'b1, 32'h08, 32'h0C, 5'd3,  32'h00000002, 1'b0, MEM_NONE, 32'h0},
    '{32'h40208233, 1'b1, 32'h0C, 32'h10, 5'd4,  32'h00000008, 1'b0, MEM_NONE, 32'h0},
    '{32'h00309293, 1'b1, 32'h10, 32'h14, 5'd5,  32'h00000028, 1'b0, MEM_NONE, 32'h0},
    '{32'h40115313, 1'b1, 32'h14, 32'h18, 5'd6,  32'hFFFFFFFE, 1'b0, MEM_NONE, 32'h0},
    '{32'h01C15393, 1'b1, 32'h18, 32'h1C, 5'd7,  32'h0000000F, 1'b0, MEM_NONE, 32'h0},
    '{32'h00112433, 1'b1, 32'h1C, 32'h20, 5'd8,  32'h00000001, 1'b0, MEM_NONE, 32'h0},
    '{32'h001134B3, 1'b1, 32'h20, 32'h24, 5'd9,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    '{32'h12345537, 1'b1, 32'h24, 32'h28, 5'd10, 32'h12345000, 1'b0, MEM_NONE, 32'h0},
    '{32'h67856513, 1'b1, 32'h28, 32'h2C, 5'd10, 32'h12345678, 1'b0, MEM_NONE, 32'h0},
    '{32'h001545B3, 1'b1, 32'h2C, 32'h30, 5'd11, 32'h1234567D, 1'b0, MEM_NONE, 32'h0},
    // write to x0, then read it back
    '{32'h00708013, 1'b1, 32'h30, 32'h34, 5'd0,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    '{32'h00100633, 1'b1, 32'h34, 32'h38, 5'd12, 32'h00000005, 1'b0, MEM_NONE, 32'h0},
    // sw, lw of the same word, lw of a preloaded word
    '{32'h00A02823, 1'b1, 32'h38, 32'h3C, 5'd0,  32'h12345678, 1'b0, MEM_STORE, 32'h10},
    '{32'h01002683, 1'b1, 32'h3C, 32'h40, 5'd13, 32'h12345678, 1'b0, MEM_NONE, 32'h0},
    '{32'h02002703, 1'b1, 32'h40, 32'h44, 5'd14, 32'h00000000, 1'b0, MEM_PRELOAD, 32'h20},
    // beq taken, bne not taken, bne taken, beq not taken
    '{32'h00C08463, 1'b1, 32'h44, 32'h4C, 5'd0,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    '{32'h00100793, 1'b0, 32'h48, 32'h4C, 5'd15, 32'h00000001, 1'b0, MEM_NONE, 32'h0},
    '{32'h00C09463, 1'b1, 32'h4C, 32'h50, 5'd0,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    '{32'h00209463, 1'b1, 32'h50, 32'h58, 5'd0,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    '{32'h00200793, 1'b0, 32'h54, 32'h58, 5'd15, 32'h00000002, 1'b0, MEM_NONE, 32'h0},
    '{32'h00208463, 1'b1, 32'h58, 32'h5C, 5'd0,  32'h00000000, 1'b0, MEM_NONE, 32'h0},
    // jal links pc plus 4 and skips two rows
    '{32'h00C0086F, 1'b1, 32'h5C, 32'h68, 5'd16, 32'h00000060, 1'b0, MEM_NONE, 32'h0},
    '{32'h00300793, 1'b0, 32'h60, 32'h64, 5'd15, 32'h00000003, 1'b0, MEM_NONE, 32'h0},
    '{32'h00400793, 1'b0, 32'h64, 32'h68, 5'd15, 32'h00000004, 1'b0, MEM_NONE, 32'h0},
    // sb is not supported, so it traps and stores nothing
    '{32'h00100023, 1'b1, 32'h68, 32'h6C, 5'd0,  32'h00000000, 1'b1, MEM_NONE, 32'h0},
    '{32'h00978893, 1'b1, 32'h6C, 32'h70, 5'd17, 32'h00000009, 1'b0, MEM_NONE, 32'h0}
};

`endif

// ==== bench/tb_rvvi_wrapper.sv ====
`timescale 1ns/1ns

module tb_rvvi_wrapper;

    logic                clk_i;
    logic                rst_n_i;
    logic [31:0]         imem_rdata_i;
    logic [31:0]         imem_addr_o;
    logic [31:0]         dmem_rdata_i;
    rv_pkg::dmem_req_t   dmem_req_o;
    rv_pkg::rvvi_trace_t rvvi_o;

    `include "tb_program.svh"

    logic [31:0]       imem [28];
    logic [31:0]       dmem [16];
    logic [31:0]       preload [16];
    rv_pkg::dmem_req_t expected_stores [$];

    rvvi_wrapper i_rvvi_wrapper (
        .clk_i        ( clk_i ),
        .rst_n_i      ( rst_n_i ),
        .imem_rdata_i ( imem_rdata_i ),
        .imem_addr_o  ( imem_addr_o ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .dmem_req_o   ( dmem_req_o ),
        .rvvi_o       ( rvvi_o )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // past the end of the program the core fetches nops
    assign imem_rdata_i = (imem_addr_o[31:2] < $size(imem)) ? imem[imem_addr_o[6:2]]
                                                              : 32'h0000_0013;

    // outside the 64 byte window a read returns the inverted address
    assign dmem_rdata_i = (dmem_req_o.addr[31:6] == '0) ? dmem[dmem_req_o.addr[5:2]]
                                                          : ~dmem_req_o.addr;

    always @(posedge clk_i) begin
        if (rst_n_i && dmem_req_o.wen && (dmem_req_o.addr[31:6] == '0)) begin
            dmem[dmem_req_o.addr[5:2]] <= dmem_req_o.wdata;
        end
    end

    function automatic logic [31:0] next_xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s: got %0h, expected %0h",
                                        name, actual, expected));
        end
    endtask

    task automatic check_trace(input rv_pkg::rvvi_trace_t actual,
                               input rv_pkg::rvvi_trace_t expected);
        compare_field("rvvi_o.order", actual.order, expected.order);
        compare_field("rvvi_o.insn", actual.insn, expected.insn);
        compare_field("rvvi_o.trap", actual.trap, expected.trap);
        compare_field("rvvi_o.pc_rdata", actual.pc_rdata, expected.pc_rdata);
        compare_field("rvvi_o.pc_wdata", actual.pc_wdata, expected.pc_wdata);
        compare_field("rvvi_o.x_wb", actual.x_wb, expected.x_wb);
        for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
            compare_field($sformatf("rvvi_o.x_wdata[%0d]", i),
                          actual.x_wdata[i], expected.x_wdata[i]);
        end
    endtask

    task automatic check_store(input rv_pkg::dmem_req_t actual,
                               input rv_pkg::dmem_req_t expected);
        compare_field("dmem_req_o.addr", actual.addr, expected.addr);
        compare_field("dmem_req_o.wdata", actual.wdata, expected.wdata);
        compare_field("dmem_req_o.ben", actual.ben, expected.ben);
    endtask

    // one writeback bit at rd, none for x0
    function automatic rv_pkg::rvvi_trace_t expected_trace(input prog_row_t row,
                                                           input logic [63:0] order);
        rv_pkg::rvvi_trace_t t;
        logic [31:0]         value;
        t          = '0;
        t.valid    = 1'b1;
        t.order    = order;
        t.insn     = row.insn;
        t.trap     = row.trap;
        t.pc_rdata = row.pc;
        t.pc_wdata = row.pc_wdata;
        value      = (row.mem == MEM_PRELOAD) ? preload[row.addr[5:2]] : row.wdata;
        if (row.rd != 5'd0) begin
            t.x_wb[row.rd]    = 1'b1;
            t.x_wdata[row.rd] = value;
        end
        return t;
    endfunction

    task automatic load_memories();
        logic [31:0]       state;
        rv_pkg::dmem_req_t req;
        state = 32'd31826;
        for (int i = 0; i < $size(imem); i++) begin
            imem[i] = prog_table[i].insn;
        end
        for (int i = 0; i < $size(dmem); i++) begin
            state      = next_xorshift(state);
            dmem[i]    = state;
            preload[i] = state;
        end
        for (int i = 0; i < $size(prog_table); i++) begin
            if (prog_table[i].retires && (prog_table[i].mem == MEM_STORE)) begin
                req.addr  = prog_table[i].addr;
                req.wdata = prog_table[i].wdata;
                req.wen   = 1'b1;
                req.ben   = 4'hF;
                expected_stores.push_back(req);
            end
        end
    endtask

    // gives up after 20 cycles without a valid record
    task automatic wait_for_trace(input prog_row_t row, output rv_pkg::rvvi_trace_t seen);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (rvvi_o.valid !== 1'b1) begin
            if (cycles >= 20) begin
                stop_with_failure($sformatf("retirement of the instruction at pc %h never arrived",
                                            row.pc));
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        seen = rvvi_o;
    endtask

    // every store must match the next one expected by the program
    always @(negedge clk_i) begin
        if (rst_n_i && dmem_req_o.wen) begin
            if (expected_stores.size() == 0) begin
                stop_with_failure($sformatf("store to address %h was not expected",
                                            dmem_req_o.addr));
            end else begin
                check_store(dmem_req_o, expected_stores.pop_front());
            end
        end
    end

    initial begin
        rv_pkg::rvvi_trace_t seen;
        logic [63:0]         order;
        logic [31:0]         last_pc_wdata;

        rst_n_i <= 1'b0;
        load_memories();
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        order         = '0;
        last_pc_wdata = rv_pkg::RESET_PC;
        for (int r = 0; r < $size(prog_table); r++) begin
            // rows behind a taken branch or jump never retire
            if (prog_table[r].retires) begin
                wait_for_trace(prog_table[r], seen);
                check_trace(seen, expected_trace(prog_table[r], order));
                compare_field("rvvi_o.pc_rdata vs previous pc_wdata",
                              seen.pc_rdata, last_pc_wdata);
                last_pc_wdata = prog_table[r].pc_wdata;
                order++;
            end
        end

        if (expected_stores.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_with_failure("a store of the program never reached the data memory");
        end
    end

endmodule

// ==== sim.f ====
+incdir+bench
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/core.sv
src/rvfi_tracker.sv
src/rvvi_wrapper.sv
bench/tb_rvvi_wrapper.sv
